/* hdl/tx_pkg.sv */
package tx_pkg;

    // address width of the 512-byte frame buffer
    localparam int addr_w = 9;

    typedef logic [7:0] byte_t;

    // fixed header bytes
    localparam byte_t preamble_byte    = 8'h55;
    localparam byte_t sfd_byte         = 8'hD0;

    // frame type that asks the receiver for an acknowledgement
    localparam byte_t ack_request_type = 8'h32;

    // one access request on the shared buffer port
    typedef struct packed {
        logic              req;
        logic              we;
        logic [addr_w-1:0] addr;
        byte_t             wdata;
    } buf_req_t;

    // description of the frame sitting in the buffer
    typedef struct packed {
        logic [addr_w-1:0] len;
        byte_t             ftype;
        logic              valid;
    } frame_info_t;

endpackage

/* hdl/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer (
    input  logic                       clk,
    input  logic                       mem_we,
    input  logic [tx_pkg::addr_w-1:0]  mem_addr,
    input  tx_pkg::byte_t              mem_wdata,
    output tx_pkg::byte_t              mem_rdata
);

    localparam int depth = 2 ** tx_pkg::addr_w;

    tx_pkg::byte_t mem [depth];

    // registered read with data one clock after the address
    always_ff @(posedge clk) begin
        if (mem_we)
            mem[mem_addr] <= mem_wdata;
        mem_rdata <= mem[mem_addr];
    end

endmodule

/* hdl/buffer_arbiter.sv */
`timescale 1ns/1ps

module buffer_arbiter (
    input  tx_pkg::buf_req_t           ld_req,
    input  tx_pkg::buf_req_t           tx_req,
    output logic                       ld_grant,
    output logic                       tx_grant,
    output logic                       mem_we,
    output logic [tx_pkg::addr_w-1:0]  mem_addr,
    output tx_pkg::byte_t              mem_wdata
);

    tx_pkg::buf_req_t sel;

    // sender has priority so a read never waits
    assign tx_grant = tx_req.req;
    assign ld_grant = ld_req.req && !tx_req.req;

    always_comb begin
        if (tx_req.req)
            sel = tx_req;
        else
            sel = ld_req;
    end

    // only the granted side may write
    assign mem_we    = sel.req && sel.we;
    assign mem_addr  = sel.addr;
    assign mem_wdata = sel.wdata;

endmodule

/* hdl/frame_loader.sv */
`timescale 1ns/1ps

module frame_loader #(
    parameter int preamble_len = 2,
    parameter int max_payload  = 255
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 xvalid,
    input  logic                 xsend,
    input  tx_pkg::byte_t        uart_in,
    input  tx_pkg::byte_t        mac,
    input  logic                 grant,
    input  logic                 frame_release,
    output logic                 xrdy,
    output tx_pkg::buf_req_t     ld_req,
    output tx_pkg::frame_info_t  info
);

    localparam int aw = tx_pkg::addr_w;
    // destination sits right after the preamble and the sfd
    localparam logic [aw-1:0] dest_pos = aw'(preamble_len + 1);
    localparam logic [aw-1:0] pre_last = aw'(preamble_len - 1);
    localparam logic [aw-1:0] pay_last = aw'(max_payload - 1);

    typedef enum logic [2:0] {ld_dest, ld_pre, ld_sfd, ld_mac, ld_type, ld_pay, ld_ready} state_t;

    state_t          state;
    logic [aw-1:0]   wr_ptr;
    logic [aw-1:0]   pay_cnt;
    logic            hold_valid;
    tx_pkg::byte_t   hold_data;
    logic            hold_last;
    logic [aw-1:0]   len_q;
    tx_pkg::byte_t   ftype_q;
    logic            info_valid;

    // request and host handshake
    always_comb begin
        ld_req = '0;
        ld_req.we = 1'b1;
        xrdy = 1'b0;
        case (state)
            ld_dest: begin
                ld_req.req   = hold_valid;
                ld_req.addr  = dest_pos;
                ld_req.wdata = hold_data;
                xrdy = !hold_valid;
            end
            ld_pre: begin
                ld_req.req   = 1'b1;
                ld_req.addr  = wr_ptr;
                ld_req.wdata = tx_pkg::preamble_byte;
            end
            ld_sfd: begin
                ld_req.req   = 1'b1;
                ld_req.addr  = wr_ptr;
                ld_req.wdata = tx_pkg::sfd_byte;
            end
            ld_mac: begin
                ld_req.req   = 1'b1;
                ld_req.addr  = wr_ptr;
                ld_req.wdata = mac;
            end
            ld_type, ld_pay: begin
                ld_req.req   = hold_valid;
                ld_req.addr  = wr_ptr;
                ld_req.wdata = hold_data;
                xrdy = !hold_valid;
            end
            default: ;
        endcase
    end

    // host byte and frame fields
    always_ff @(posedge clk) begin
        if (xrdy && xvalid) begin
            hold_data <= uart_in;
            hold_last <= xsend;
        end
        if (state == ld_type && grant)
            ftype_q <= hold_data;
        if (state == ld_pay && grant)
            len_q <= wr_ptr + aw'(1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ld_dest;
            wr_ptr     <= '0;
            pay_cnt    <= '0;
            hold_valid <= 1'b0;
            info_valid <= 1'b0;
        end else begin
            if (xrdy && xvalid)
                hold_valid <= 1'b1;
            case (state)
                ld_dest: if (grant) begin
                    hold_valid <= 1'b0;
                    wr_ptr     <= '0;
                    state      <= ld_pre;
                end
                ld_pre: if (grant) begin
                    wr_ptr <= wr_ptr + aw'(1);
                    if (wr_ptr == pre_last)
                        state <= ld_sfd;
                end
                ld_sfd: if (grant) begin
                    // skip over the destination already in place
                    wr_ptr <= wr_ptr + aw'(2);
                    state  <= ld_mac;
                end
                ld_mac: if (grant) begin
                    wr_ptr <= wr_ptr + aw'(1);
                    state  <= ld_type;
                end
                ld_type: if (grant) begin
                    hold_valid <= 1'b0;
                    wr_ptr     <= wr_ptr + aw'(1);
                    pay_cnt    <= '0;
                    state      <= ld_pay;
                end
                ld_pay: if (grant) begin
                    hold_valid <= 1'b0;
                    wr_ptr     <= wr_ptr + aw'(1);
                    pay_cnt    <= pay_cnt + aw'(1);
                    if (hold_last || pay_cnt == pay_last) begin
                        info_valid <= 1'b1;
                        state      <= ld_ready;
                    end
                end
                ld_ready: if (frame_release) begin
                    info_valid <= 1'b0;
                    state      <= ld_dest;
                end
                default: state <= ld_dest;
            endcase
        end
    end

    assign info = '{len: len_q, ftype: ftype_q, valid: info_valid};

endmodule

/* hdl/frame_sender.sv */
`timescale 1ns/1ps

module frame_sender (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 send_start,
    input  tx_pkg::frame_info_t  info,
    input  logic                 grant,
    input  tx_pkg::byte_t        mem_rdata,
    input  logic                 mx_rdy,
    output tx_pkg::buf_req_t     tx_req,
    output logic                 mx_valid,
    output tx_pkg::byte_t        mx_data,
    output logic                 send_done
);

    localparam int aw = tx_pkg::addr_w;

    typedef enum logic [1:0] {sd_idle, sd_read, sd_fetch, sd_out} state_t;

    state_t         state;
    logic [aw-1:0]  rd_ptr;

    // the sender only ever reads
    always_comb begin
        tx_req       = '0;
        tx_req.req   = (state == sd_read);
        tx_req.addr  = rd_ptr;
    end

    // ram output lands here one clock after the read
    always_ff @(posedge clk) begin
        if (state == sd_fetch)
            mx_data <= mem_rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= sd_idle;
            rd_ptr    <= '0;
            mx_valid  <= 1'b0;
            send_done <= 1'b0;
        end else begin
            send_done <= 1'b0;
            case (state)
                sd_idle: begin
                    // every attempt starts at byte 0
                    if (send_start && info.valid) begin
                        rd_ptr <= '0;
                        state  <= sd_read;
                    end
                end
                sd_read: if (grant) begin
                    rd_ptr <= rd_ptr + aw'(1);
                    state  <= sd_fetch;
                end
                sd_fetch: begin
                    mx_valid <= 1'b1;
                    state    <= sd_out;
                end
                sd_out: if (mx_rdy) begin
                    mx_valid <= 1'b0;
                    if (rd_ptr == info.len) begin
                        send_done <= 1'b1;
                        state     <= sd_idle;
                    end else begin
                        state <= sd_read;
                    end
                end
                default: state <= sd_idle;
            endcase
        end
    end

endmodule

/* hdl/medium_access.sv */
`timescale 1ns/1ps

module medium_access #(
    parameter int difs_ticks        = 640,
    parameter int slot_ticks        = 8,
    parameter int ack_timeout_ticks = 2048,
    parameter int max_attempts      = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 enb_out_8,
    input  logic                 cardet,
    input  logic                 ack_received,
    input  tx_pkg::frame_info_t  info,
    input  logic                 send_done,
    output logic                 send_start,
    output logic                 frame_release,
    output logic                 ack_rcv_clr,
    output logic                 xbusy,
    output logic [3:0]           xerrcnt
);

    localparam int backoff_top = 8 * slot_ticks;
    localparam int wait_top = (difs_ticks > ack_timeout_ticks) ? difs_ticks : ack_timeout_ticks;
    localparam int tick_top = (wait_top > backoff_top) ? wait_top : backoff_top;
    localparam int tick_w = $clog2(tick_top + 1);
    localparam int att_w = $clog2(max_attempts + 1);

    typedef enum logic [2:0] {ma_idle, ma_difs, ma_backoff, ma_sending, ma_ack_wait} state_t;

    state_t             state;
    logic [tick_w-1:0]  tick_cnt;
    logic [tick_w-1:0]  slot_goal;
    logic [att_w-1:0]   attempt_cnt;
    logic [2:0]         rnd;

    // random slot count 1..8 from the free-running counter
    function automatic logic [tick_w-1:0] draw_slots(input logic [2:0] r);
        return tick_w'((int'(r) + 1) * slot_ticks);
    endfunction

    assign xbusy = (state != ma_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ma_idle;
            tick_cnt      <= '0;
            slot_goal     <= '0;
            attempt_cnt   <= '0;
            rnd           <= '0;
            xerrcnt       <= '0;
            send_start    <= 1'b0;
            frame_release <= 1'b0;
            ack_rcv_clr   <= 1'b0;
        end else begin
            rnd           <= rnd + 3'd1;
            send_start    <= 1'b0;
            frame_release <= 1'b0;
            ack_rcv_clr   <= 1'b0;
            case (state)
                ma_idle: begin
                    // the release pulse is still in flight while valid drops
                    if (info.valid && !frame_release) begin
                        tick_cnt    <= '0;
                        attempt_cnt <= '0;
                        state       <= ma_difs;
                    end
                end
                ma_difs: if (enb_out_8) begin
                    tick_cnt <= tick_cnt + tick_w'(1);
                    if (tick_cnt == tick_w'(difs_ticks - 1)) begin
                        tick_cnt <= '0;
                        if (cardet) begin
                            slot_goal <= draw_slots(rnd);
                            state     <= ma_backoff;
                        end else begin
                            send_start <= 1'b1;
                            state      <= ma_sending;
                        end
                    end
                end
                ma_backoff: if (enb_out_8) begin
                    tick_cnt <= tick_cnt + tick_w'(1);
                    if (tick_cnt == slot_goal - tick_w'(1)) begin
                        tick_cnt <= '0;
                        if (cardet) begin
                            slot_goal <= draw_slots(rnd);
                        end else begin
                            send_start <= 1'b1;
                            state      <= ma_sending;
                        end
                    end
                end
                ma_sending: if (send_done) begin
                    tick_cnt <= '0;
                    if (info.ftype == tx_pkg::ack_request_type) begin
                        state <= ma_ack_wait;
                    end else begin
                        frame_release <= 1'b1;
                        state         <= ma_idle;
                    end
                end
                ma_ack_wait: if (enb_out_8) begin
                    tick_cnt <= tick_cnt + tick_w'(1);
                    if (tick_cnt == tick_w'(ack_timeout_ticks - 1)) begin
                        tick_cnt <= '0;
                        if (ack_received) begin
                            ack_rcv_clr   <= 1'b1;
                            frame_release <= 1'b1;
                            state         <= ma_idle;
                        end else if (attempt_cnt == att_w'(max_attempts)) begin
                            // out of retries so the loss is counted
                            xerrcnt       <= xerrcnt + 4'd1;
                            frame_release <= 1'b1;
                            state         <= ma_idle;
                        end else begin
                            attempt_cnt <= attempt_cnt + att_w'(1);
                            state       <= ma_difs;
                        end
                    end
                end
                default: state <= ma_idle;
            endcase
        end
    end

endmodule

/* hdl/tx_top.sv */
`timescale 1ns/1ps

module tx_top #(
    parameter int preamble_len      = 2,
    parameter int max_payload       = 255,
    parameter int difs_ticks        = 640,
    parameter int slot_ticks        = 8,
    parameter int ack_timeout_ticks = 2048,
    parameter int max_attempts      = 5
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           xvalid,
    input  logic           xsend,
    input  tx_pkg::byte_t  uart_in,
    input  tx_pkg::byte_t  mac,
    input  logic           cardet,
    input  logic           enb_out_8,
    input  logic           ack_received,
    input  logic           mx_rdy,
    output logic           xrdy,
    output logic           mx_valid,
    output tx_pkg::byte_t  mx_data,
    output logic           ack_rcv_clr,
    output logic           xbusy,
    output logic [3:0]     xerrcnt
);

    tx_pkg::buf_req_t             ld_req;
    tx_pkg::buf_req_t             tx_req;
    logic                         ld_grant;
    logic                         tx_grant;
    logic                         mem_we;
    logic [tx_pkg::addr_w-1:0]    mem_addr;
    tx_pkg::byte_t                mem_wdata;
    tx_pkg::byte_t                mem_rdata;
    tx_pkg::frame_info_t          info;
    logic                         send_start;
    logic                         send_done;
    logic                         frame_release;

    frame_loader #(
        .preamble_len (preamble_len),
        .max_payload  (max_payload)
    ) u_loader (
        .clk           (clk),
        .rst           (rst),
        .xvalid        (xvalid),
        .xsend         (xsend),
        .uart_in       (uart_in),
        .mac           (mac),
        .grant         (ld_grant),
        .frame_release (frame_release),
        .xrdy          (xrdy),
        .ld_req        (ld_req),
        .info          (info)
    );

    buffer_arbiter u_arbiter (
        .ld_req    (ld_req),
        .tx_req    (tx_req),
        .ld_grant  (ld_grant),
        .tx_grant  (tx_grant),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    frame_buffer u_buffer (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    medium_access #(
        .difs_ticks        (difs_ticks),
        .slot_ticks        (slot_ticks),
        .ack_timeout_ticks (ack_timeout_ticks),
        .max_attempts      (max_attempts)
    ) u_mac (
        .clk           (clk),
        .rst           (rst),
        .enb_out_8     (enb_out_8),
        .cardet        (cardet),
        .ack_received  (ack_received),
        .info          (info),
        .send_done     (send_done),
        .send_start    (send_start),
        .frame_release (frame_release),
        .ack_rcv_clr   (ack_rcv_clr),
        .xbusy         (xbusy),
        .xerrcnt       (xerrcnt)
    );

    frame_sender u_sender (
        .clk        (clk),
        .rst        (rst),
        .send_start (send_start),
        .info       (info),
        .grant      (tx_grant),
        .mem_rdata  (mem_rdata),
        .mx_rdy     (mx_rdy),
        .tx_req     (tx_req),
        .mx_valid   (mx_valid),
        .mx_data    (mx_data),
        .send_done  (send_done)
    );

endmodule

/* test/tx_assert.sv */
`timescale 1ns/1ps

module tx_assert (
    input logic          clk,
    input logic          rst,
    input logic          mx_valid,
    input logic          mx_rdy,
    input tx_pkg::byte_t mx_data,
    input logic          xbusy,
    input logic          ack_rcv_clr
);

    logic stable_fail = 1'b0;
    logic busy_fail   = 1'b0;
    logic pulse_fail  = 1'b0;

    // a stalled byte stays put until it is taken
    assert property (@(posedge clk) disable iff (rst)
        mx_valid && !mx_rdy |=> mx_valid && $stable(mx_data))
    else begin
        $error("mx_data changed or mx_valid fell while mx_rdy was low");
        stable_fail = 1'b1;
    end

    assert property (@(posedge clk) disable iff (rst) mx_valid |-> xbusy)
    else begin
        $error("mx_valid high while xbusy is low");
        busy_fail = 1'b1;
    end

    assert property (@(posedge clk) disable iff (rst) ack_rcv_clr |=> !ack_rcv_clr)
    else begin
        $error("ack_rcv_clr longer than one cycle");
        pulse_fail = 1'b1;
    end

endmodule

bind tx_top tx_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .mx_valid    (mx_valid),
    .mx_rdy      (mx_rdy),
    .mx_data     (mx_data),
    .xbusy       (xbusy),
    .ack_rcv_clr (ack_rcv_clr)
);

/* include/tx_tests.svh */
`ifndef tx_tests_svh
`define tx_tests_svh

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
        $display("mismatch in %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        $display("Finished with errors");
        $fatal(1, "check failed");
    end
endtask

task automatic step();
    @(posedge clk);
    #2;
endtask

// one host strobe once the loader shows xrdy
task automatic host_byte(input tx_pkg::byte_t data, input logic last);
    while (!xrdy)
        step();
    xvalid  = 1'b1;
    xsend   = last;
    uart_in = data;
    step();
    xvalid = 1'b0;
    xsend  = 1'b0;
endtask

task automatic fill_payload(input int count, input tx_pkg::byte_t first);
    pay_q.delete();
    for (int i = 0; i < count; i++)
        pay_q.push_back(8'(first + 7 * i));
endtask

task automatic load_frame(input tx_pkg::byte_t dest, input tx_pkg::byte_t ftype);
    host_byte(dest, 1'b0);
    host_byte(ftype, 1'b0);
    foreach (pay_q[i])
        host_byte(pay_q[i], i == pay_q.size() - 1);
endtask

// busy period of one frame plus a clock for the last pulses
task automatic wait_frame_done();
    while (!xbusy)
        step();
    while (xbusy)
        step();
    step();
endtask

// copies of the expected frame must follow rx_q[base]
task automatic expect_frame(input string name, input tx_pkg::byte_t dest,
                            input tx_pkg::byte_t ftype, input int base, input int copies);
    int n;
    exp_q.delete();
    repeat (preamble_len)
        exp_q.push_back(preamble_val);
    exp_q.push_back(sfd_val);
    exp_q.push_back(dest);
    exp_q.push_back(node_mac);
    exp_q.push_back(ftype);
    foreach (pay_q[i])
        exp_q.push_back(pay_q[i]);
    n = exp_q.size();
    check($sformatf("%s byte count", name), n * copies, rx_q.size() - base);
    for (int i = 0; i < n * copies; i++)
        check($sformatf("%s byte %0d", name, i), 32'(exp_q[i % n]), 32'(rx_q[base + i]));
endtask

task automatic test_reset_values();
    check("reset xrdy", 1, 32'(xrdy));
    check("reset mx_valid", 0, 32'(mx_valid));
    check("reset ack_rcv_clr", 0, 32'(ack_rcv_clr));
    check("reset xbusy", 0, 32'(xbusy));
    check("reset xerrcnt", 0, 32'(xerrcnt));
endtask

task automatic test_frame_format();
    int base;
    base = rx_q.size();
    fill_payload(4, 8'h10);
    load_frame(8'h3C, 8'h30);
    wait_frame_done();
    check("frame_format length", 10, rx_q.size() - base);
    expect_frame("frame_format", 8'h3C, 8'h30, base, 1);
endtask

task automatic test_payload_cap();
    int base;
    base = rx_q.size();
    fill_payload(20, 8'h40);
    host_byte(8'h5A, 1'b0);
    host_byte(8'h31, 1'b0);
    for (int i = 0; i < 20; i++) begin
        if (i < max_payload) begin
            host_byte(pay_q[i], 1'b0);
        end else begin
            // buffer already closed so the strobe is ignored
            check("payload_cap xrdy", 0, 32'(xrdy));
            xvalid  = 1'b1;
            uart_in = pay_q[i];
            step();
            xvalid = 1'b0;
        end
    end
    wait_frame_done();
    while (pay_q.size() > max_payload)
        void'(pay_q.pop_back());
    expect_frame("payload_cap", 8'h5A, 8'h31, base, 1);
endtask

task automatic test_carrier_sense();
    int base;
    base = rx_q.size();
    fill_payload(3, 8'h80);
    cardet = 1'b1;
    load_frame(8'h21, 8'h30);
    while (!xbusy)
        step();
    repeat (100) begin
        step();
        check("carrier_sense mx_valid", 0, 32'(mx_valid));
    end
    cardet = 1'b0;
    wait_frame_done();
    expect_frame("carrier_sense", 8'h21, 8'h30, base, 1);
endtask

task automatic test_ack_received();
    int         base;
    int         clr0;
    logic [3:0] err0;
    base = rx_q.size();
    clr0 = clr_pulses;
    err0 = xerrcnt;
    fill_payload(2, 8'hC0);
    ack_received = 1'b1;
    load_frame(8'h44, ack_type);
    wait_frame_done();
    ack_received = 1'b0;
    expect_frame("ack_received", 8'h44, ack_type, base, 1);
    check("ack_received clr pulses", 1, clr_pulses - clr0);
    check("ack_received xerrcnt", 32'(err0), 32'(xerrcnt));
endtask

task automatic test_ack_failed();
    int         base;
    int         clr0;
    logic [3:0] err_exp;
    base = rx_q.size();
    clr0 = clr_pulses;
    err_exp = xerrcnt + 4'd1;
    fill_payload(3, 8'hE1);
    load_frame(8'h45, ack_type);
    wait_frame_done();
    // first try and two retries
    expect_frame("ack_failed", 8'h45, ack_type, base, 3);
    check("ack_failed clr pulses", 0, clr_pulses - clr0);
    check("ack_failed xerrcnt", 32'(err_exp), 32'(xerrcnt));
endtask

task automatic test_back_pressure();
    int base;
    int stall0;
    base = rx_q.size();
    stall0 = stalls;
    random_rdy = 1'b1;
    fill_payload(4, 8'h10);
    load_frame(8'h3C, 8'h30);
    wait_frame_done();
    random_rdy = 1'b0;
    expect_frame("back_pressure", 8'h3C, 8'h30, base, 1);
    check("back_pressure stalls seen", 1, 32'(stalls > stall0));
endtask

`endif

/* test/tx_tb.sv */
`timescale 1ns/1ps

module tx_tb;

    localparam int preamble_len = 2;
    localparam int max_payload  = 16;
    // all tests need a few thousand cycles at most
    localparam int cycle_limit  = 20000;

    localparam tx_pkg::byte_t preamble_val = 8'h55;
    localparam tx_pkg::byte_t sfd_val      = 8'hD0;
    localparam tx_pkg::byte_t ack_type     = 8'h32;
    localparam tx_pkg::byte_t node_mac     = 8'hA7;

    logic          clk = 1'b0;
    logic          rst;
    logic          xvalid;
    logic          xsend;
    tx_pkg::byte_t uart_in;
    tx_pkg::byte_t mac;
    logic          cardet;
    logic          enb_out_8 = 1'b0;
    logic          ack_received;
    logic          mx_rdy = 1'b1;
    logic          xrdy;
    logic          mx_valid;
    tx_pkg::byte_t mx_data;
    logic          ack_rcv_clr;
    logic          xbusy;
    logic [3:0]    xerrcnt;

    int            seed = 37313;
    int            cycles = 0;
    int            clr_pulses = 0;
    int            stalls = 0;
    logic          random_rdy = 1'b0;
    logic [1:0]    tick_phase = 2'd0;
    logic [31:0]   rnd_word;
    tx_pkg::byte_t rx_q[$];
    tx_pkg::byte_t pay_q[$];
    tx_pkg::byte_t exp_q[$];

    tx_top #(
        .preamble_len      (preamble_len),
        .max_payload       (max_payload),
        .difs_ticks        (20),
        .slot_ticks        (4),
        .ack_timeout_ticks (30),
        .max_attempts      (2)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .xvalid       (xvalid),
        .xsend        (xsend),
        .uart_in      (uart_in),
        .mac          (mac),
        .cardet       (cardet),
        .enb_out_8    (enb_out_8),
        .ack_received (ack_received),
        .mx_rdy       (mx_rdy),
        .xrdy         (xrdy),
        .mx_valid     (mx_valid),
        .mx_data      (mx_data),
        .ack_rcv_clr  (ack_rcv_clr),
        .xbusy        (xbusy),
        .xerrcnt      (xerrcnt)
    );

    always #20 clk = ~clk;

    // tick every fourth cycle and a random or steady receiver ready
    always @(posedge clk) begin
        #2;
        tick_phase = tick_phase + 2'd1;
        enb_out_8 = (tick_phase == 2'd0);
        if (random_rdy) begin
            rnd_word = $random(seed);
            mx_rdy = rnd_word[0];
        end else begin
            mx_rdy = 1'b1;
        end
    end

    // receiver model
    always @(posedge clk) begin
        if (!rst) begin
            if (mx_valid && mx_rdy)
                rx_q.push_back(mx_data);
            if (mx_valid && !mx_rdy)
                stalls++;
            if (ack_rcv_clr)
                clr_pulses++;
        end
    end

    always @(negedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Finished with errors");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", cycle_limit);
        end else if (uut.u_assert.stable_fail || uut.u_assert.busy_fail ||
                     uut.u_assert.pulse_fail) begin
            $display("Finished with errors");
            $fatal(1, "an assertion on the DUT outputs failed");
        end
    end

    `include "tx_tests.svh"

    initial begin
        rst          = 1'b1;
        xvalid       = 1'b0;
        xsend        = 1'b0;
        uart_in      = '0;
        mac          = node_mac;
        cardet       = 1'b0;
        ack_received = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_values();
        test_frame_format();
        test_payload_cap();
        test_carrier_sense();
        test_ack_received();
        test_ack_failed();
        test_back_pressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* project.f */
+incdir+include
hdl/tx_pkg.sv
hdl/frame_buffer.sv
hdl/buffer_arbiter.sv
hdl/frame_loader.sv
hdl/frame_sender.sv
hdl/medium_access.sv
hdl/tx_top.sv
test/tx_assert.sv
test/tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tx_tb \
    -f project.f \
    -o tx_sim

./obj_dir/tx_sim +verilator+error+limit+100
